/* src/mixer_cfg_pkg.sv */
// APB transport types, register map and configuration fields of the colour mixer, imported by the register block and the top level
package mixer_cfg_pkg;

	// ==========================================================================
	// APB transport, 8-bit data on a 12-bit address
	// ==========================================================================
	typedef struct packed {
		logic [11:0] paddr;
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [7:0] prdata;
		logic       pready;
		logic       pslverr;
	} apb_rsp_t;

	// ==========================================================================
	// Register map
	// ==========================================================================
	localparam logic [11:0] REG_COLOUR12  = 12'h000;	// Tile 1 in 2..0, tile 2 in 6..4
	localparam logic [11:0] REG_COLOUR3   = 12'h004;	// Tile 3 in 2..0, sprite in 5..4
	localparam logic [11:0] REG_PRIORITY  = 12'h008;
	localparam logic [11:0] REG_HIT       = 12'h00C;	// Read only
	localparam logic [11:0] REG_HIT_CLEAR = 12'h010;	// Write only, data ignored
	localparam logic [11:0] PALETTE_BASE  = 12'h100;	// Low byte at +0, bit 8 at +2
	localparam logic [11:0] PRIO_BASE     = 12'h800;

	localparam int PALETTE_DEPTH = 64;
	localparam int PRIO_DEPTH    = 256;

	// Configuration fields
	typedef logic [2:0] tile_code_t;
	typedef logic [1:0] sprite_code_t;
	typedef logic [4:0] prio_mode_t;	// Bit 4 picks the high half of the entry

	typedef struct packed {
		tile_code_t   tile1_code;
		tile_code_t   tile2_code;
		tile_code_t   tile3_code;
		sprite_code_t sprite_code;
		prio_mode_t   prio_mode;
	} mixer_cfg_t;

endpackage

/* src/pixel_pkg.sv */
// Pixel path types shared by the layer mixer, the collision logic and the colour tables
package pixel_pkg;

	// One pixel of every layer, as delivered by the video front end
	typedef struct packed {
		logic [2:0] tile1;
		logic [2:0] tile2;
		logic [2:0] tile3;
		logic [3:0] sprite;	// Bit 3 only widens the palette index
		logic       blank;
	} layer_pix_t;

	// 3-3-3 colour, red in the top bits as in the palette word
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} rgb_t;

	// ==========================================================================
	// Layer select codes as stored in the priority table
	// ==========================================================================
	typedef enum logic [1:0] {
		SEL_SPRITE = 2'b00,
		SEL_TILE1  = 2'b01,
		SEL_TILE2  = 2'b10,
		SEL_TILE3  = 2'b11
	} layer_sel_e;

	typedef struct packed {
		layer_sel_e sel_hi;	// Used when prio_mode bit 4 is set
		layer_sel_e sel_lo;
	} prio_entry_t;

endpackage

/* src/lookup_ram.sv */
// Table with one write port and two registered read ports, used for the palette and the priority table
module lookup_ram #(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = 64,
	localparam int AW      = $clog2(DEPTH)
) (
	input  logic          clk_i,
	input  logic          we_i,
	input  logic [AW-1:0] waddr_i,
	input  entry_t        wdata_i,
	input  logic [AW-1:0] raddr_a_i,	// Pixel side
	output entry_t        rdata_a_o,
	input  logic [AW-1:0] raddr_b_i,	// Bus side
	output entry_t        rdata_b_o
);

	entry_t mem [DEPTH];

	// Reads see the old word when they hit the entry being written
	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
		rdata_a_o <= mem[raddr_a_i];
		rdata_b_o <= mem[raddr_b_i];
	end

endmodule

/* src/mixer_regs.sv */
// APB slave of the mixer: colour and priority registers, collision clear, and table access with wait states
module mixer_regs import mixer_cfg_pkg::*, pixel_pkg::*; #(
	parameter int  PAL_DEPTH = PALETTE_DEPTH,
	parameter int  PRI_DEPTH = PRIO_DEPTH,
	localparam int PAL_AW    = $clog2(PAL_DEPTH),
	localparam int PRI_AW    = $clog2(PRI_DEPTH)
) (
	input  logic              V_BLANK,
	input  logic              EXROM2,
	input  apb_req_t          apb_req_i,
	output apb_rsp_t          apb_rsp_o,
	output mixer_cfg_t        cfg_o,
	input  logic [2:0]        hit_flags_i,
	output logic              hit_clear_o,
	output logic              pal_we_o,
	output logic [PAL_AW-1:0] pal_addr_o,
	output rgb_t              pal_wdata_o,
	input  rgb_t              pal_rdata_i,
	output logic              prio_we_o,
	output logic [PRI_AW-1:0] prio_addr_o,
	output prio_entry_t       prio_wdata_o,
	input  prio_entry_t       prio_rdata_i
);

	localparam int PAL_END = int'(PALETTE_BASE) + 4 * PAL_DEPTH;
	localparam int PRI_END = int'(PRIO_BASE) + 4 * PRI_DEPTH;

	logic       access;
	logic       is_reg;
	logic       is_pal;
	logic       is_prio;
	logic       is_err;
	logic [1:0] wait_cnt;
	logic [1:0] done_cnt;
	logic       ready;
	logic       reg_wr;
	logic [8:0] pal_old;
	logic [7:0] rdata;
	mixer_cfg_t cfg_q;

	assign access = apb_req_i.psel & apb_req_i.penable;

	// ==========================================================================
	// Address decode
	// ==========================================================================
	always_comb begin
		is_reg = 1'b0;
		case (apb_req_i.paddr)
			REG_COLOUR12, REG_COLOUR3, REG_PRIORITY, REG_HIT, REG_HIT_CLEAR: is_reg = 1'b1;
			default: is_reg = 1'b0;
		endcase
		is_pal = (int'(apb_req_i.paddr) >= int'(PALETTE_BASE)) &&
			(int'(apb_req_i.paddr) < PAL_END) && !apb_req_i.paddr[0];
		is_prio = (int'(apb_req_i.paddr) >= int'(PRIO_BASE)) &&
			(int'(apb_req_i.paddr) < PRI_END) && (apb_req_i.paddr[1:0] == 2'b00);
		is_err = !(is_reg | is_pal | is_prio) ||
			(apb_req_i.pwrite && apb_req_i.paddr == REG_HIT);
	end

	// Access cycles before pready, palette writes need the old word first
	always_comb begin
		if (is_pal && apb_req_i.pwrite) begin
			done_cnt = 2'd2;
		end else if (is_pal || is_prio) begin
			done_cnt = 2'd1;
		end else begin
			done_cnt = 2'd0;
		end
	end

	assign ready = access && (wait_cnt == done_cnt);

	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			wait_cnt <= 2'd0;
		end else if (access && !ready) begin
			wait_cnt <= wait_cnt + 2'd1;
		end else begin
			wait_cnt <= 2'd0;
		end
	end

	// ==========================================================================
	// Table ports, port B follows the bus address
	// ==========================================================================
	assign pal_old     = pal_rdata_i;
	assign pal_addr_o  = apb_req_i.paddr[PAL_AW+1:2];
	assign pal_we_o    = ready & apb_req_i.pwrite & is_pal;
	assign pal_wdata_o = apb_req_i.paddr[1] ? rgb_t'({apb_req_i.pwdata[0], pal_old[7:0]})
		: rgb_t'({pal_old[8], apb_req_i.pwdata});	// Merge into the stored word

	assign prio_addr_o  = apb_req_i.paddr[PRI_AW+1:2];
	assign prio_we_o    = ready & apb_req_i.pwrite & is_prio;
	assign prio_wdata_o = prio_entry_t'(apb_req_i.pwdata[3:0]);

	// Read data
	always_comb begin
		rdata = 8'h00;
		if (is_pal) begin
			rdata = apb_req_i.paddr[1] ? {7'd0, pal_old[8]} : pal_old[7:0];
		end else if (is_prio) begin
			rdata = {4'd0, prio_rdata_i};
		end else begin
			case (apb_req_i.paddr)
				REG_COLOUR12: rdata = {1'b0, cfg_q.tile2_code, 1'b0, cfg_q.tile1_code};
				REG_COLOUR3:  rdata = {2'd0, cfg_q.sprite_code, 1'b0, cfg_q.tile3_code};
				REG_PRIORITY: rdata = {3'd0, cfg_q.prio_mode};
				REG_HIT:      rdata = {5'd0, hit_flags_i};
				default:      rdata = 8'h00;	// Clear register reads as zero
			endcase
		end
	end

	assign apb_rsp_o.prdata  = rdata;
	assign apb_rsp_o.pready  = ready;
	assign apb_rsp_o.pslverr = ready & is_err;

	// ==========================================================================
	// Configuration registers
	// ==========================================================================
	assign reg_wr = ready & apb_req_i.pwrite & is_reg & !is_err;

	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			cfg_q <= '0;
		end else if (reg_wr) begin
			case (apb_req_i.paddr)
				REG_COLOUR12: begin
					cfg_q.tile1_code <= apb_req_i.pwdata[2:0];
					cfg_q.tile2_code <= apb_req_i.pwdata[6:4];
				end
				REG_COLOUR3: begin
					cfg_q.tile3_code  <= apb_req_i.pwdata[2:0];
					cfg_q.sprite_code <= apb_req_i.pwdata[5:4];
				end
				REG_PRIORITY: cfg_q.prio_mode <= apb_req_i.pwdata[4:0];
				default: ;
			endcase
		end
	end

	assign cfg_o       = cfg_q;
	assign hit_clear_o = reg_wr && (apb_req_i.paddr == REG_HIT_CLEAR);	// One-cycle pulse

	a_penable_in_psel: assert property (@(posedge V_BLANK) disable iff (!EXROM2)
		apb_req_i.penable |-> apb_req_i.psel)
		else $error("penable high outside a selected transfer");

endmodule

/* src/layer_priority_mux.sv */
// Pixel pipeline of the mixer: priority lookup, palette lookup and blanked RGB output, three cycles deep
module layer_priority_mux import mixer_cfg_pkg::*, pixel_pkg::*; #(
	parameter int  PAL_DEPTH = PALETTE_DEPTH,
	parameter int  PRI_DEPTH = PRIO_DEPTH,
	localparam int PAL_AW    = $clog2(PAL_DEPTH),
	localparam int PRI_AW    = $clog2(PRI_DEPTH)
) (
	input  logic              V_BLANK,
	input  logic              EXROM2,
	input  layer_pix_t        pix_i,
	input  mixer_cfg_t        cfg_i,
	output logic [PRI_AW-1:0] prio_addr_o,
	input  prio_entry_t       prio_entry_i,
	output logic [PAL_AW-1:0] pal_addr_o,
	input  rgb_t              pal_entry_i,
	output rgb_t              rgb_o
);

	logic [3:0]        transp;	// tile3, tile2, tile1, sprite
	layer_pix_t        pix_d1;
	mixer_cfg_t        cfg_d1;
	layer_sel_e        sel;
	logic [PAL_AW-1:0] pal_addr_q;
	logic              blank_d2;
	logic              blank_d3;

	// ==========================================================================
	// Stage 0, priority read straight from the incoming pixel
	// ==========================================================================
	assign transp = {~|pix_i.tile3, ~|pix_i.tile2, ~|pix_i.tile1, ~|pix_i.sprite[2:0]};
	assign prio_addr_o = PRI_AW'({cfg_i.prio_mode[3:0], transp});

	// Pixel and codes travel with the table read
	always_ff @(posedge V_BLANK) begin
		pix_d1 <= pix_i;
		cfg_d1 <= cfg_i;
	end

	// ==========================================================================
	// Stage 1, layer select and palette index
	// ==========================================================================
	assign sel = cfg_d1.prio_mode[4] ? prio_entry_i.sel_hi : prio_entry_i.sel_lo;

	always_ff @(posedge V_BLANK) begin
		case (sel)
			SEL_SPRITE: pal_addr_q <= PAL_AW'({cfg_d1.sprite_code, pix_d1.sprite});
			SEL_TILE1:  pal_addr_q <= PAL_AW'({cfg_d1.tile1_code, pix_d1.tile1});
			SEL_TILE2:  pal_addr_q <= PAL_AW'({cfg_d1.tile2_code, pix_d1.tile2});
			default:    pal_addr_q <= PAL_AW'({cfg_d1.tile3_code, pix_d1.tile3});
		endcase
	end

	assign pal_addr_o = pal_addr_q;

	// Blank follows the palette read, output goes black behind it
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			blank_d2 <= 1'b1;
			blank_d3 <= 1'b1;
			rgb_o    <= '0;
		end else begin
			blank_d2 <= pix_d1.blank;
			blank_d3 <= blank_d2;
			rgb_o    <= blank_d3 ? rgb_t'('0) : pal_entry_i;
		end
	end

	// Visible pixels need a defined priority entry
	a_sel_known: assert property (@(posedge V_BLANK) disable iff (!EXROM2)
		!pix_d1.blank |-> !$isunknown(sel))
		else $error("layer select unknown for a visible pixel");

endmodule

/* src/collision_detect.sv */
// Sticky sprite-to-tile overlap flags read through the hit register and cleared by the CPU
module collision_detect import pixel_pkg::*; (
	input  logic       V_BLANK,
	input  logic       EXROM2,
	input  layer_pix_t pix_i,
	input  logic       clear_i,
	output logic [2:0] hit_flags_o
);

	logic       sprite_opaque;
	logic [2:0] tile_opaque;
	logic [2:0] hit_set;

	assign sprite_opaque = |pix_i.sprite[2:0];
	assign tile_opaque   = {|pix_i.tile3, |pix_i.tile2, |pix_i.tile1};
	assign hit_set       = (sprite_opaque && !pix_i.blank) ? tile_opaque : 3'b000;

	// Clear beats a set in the same cycle
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			hit_flags_o <= 3'b000;
		end else if (clear_i) begin
			hit_flags_o <= 3'b000;
		end else begin
			hit_flags_o <= hit_flags_o | hit_set;
		end
	end

	a_clear_empties: assert property (@(posedge V_BLANK) disable iff (!EXROM2)
		clear_i |=> (hit_flags_o == 3'b000))
		else $error("hit flags not cleared after clear");

endmodule

/* src/video_mixer_top.sv */
// Top level of the colour mixer: APB register block, palette and priority tables, pixel pipeline and collision flags
module video_mixer_top import mixer_cfg_pkg::*, pixel_pkg::*; #(
	parameter int PAL_DEPTH = PALETTE_DEPTH,
	parameter int PRI_DEPTH = PRIO_DEPTH
) (
	input  logic       V_BLANK,
	input  logic       EXROM2,
	input  apb_req_t   apb_req_i,
	output apb_rsp_t   apb_rsp_o,
	input  layer_pix_t pix_i,
	output rgb_t       rgb_o
);

	localparam int PAL_AW = $clog2(PAL_DEPTH);
	localparam int PRI_AW = $clog2(PRI_DEPTH);

	mixer_cfg_t        cfg;
	logic [2:0]        hit_flags;
	logic              hit_clear;

	logic              pal_we;
	logic [PAL_AW-1:0] pal_bus_addr;
	rgb_t              pal_wdata;
	rgb_t              pal_bus_rdata;
	logic [PAL_AW-1:0] pal_pix_addr;
	rgb_t              pal_pix_rdata;

	logic              prio_we;
	logic [PRI_AW-1:0] prio_bus_addr;
	prio_entry_t       prio_wdata;
	prio_entry_t       prio_bus_rdata;
	logic [PRI_AW-1:0] prio_pix_addr;
	prio_entry_t       prio_pix_rdata;

	// ==========================================================================
	// Bus side
	// ==========================================================================
	mixer_regs #(
		.PAL_DEPTH(PAL_DEPTH),
		.PRI_DEPTH(PRI_DEPTH)
	) u_regs (
		.V_BLANK     (V_BLANK),
		.EXROM2      (EXROM2),
		.apb_req_i   (apb_req_i),
		.apb_rsp_o   (apb_rsp_o),
		.cfg_o       (cfg),
		.hit_flags_i (hit_flags),
		.hit_clear_o (hit_clear),
		.pal_we_o    (pal_we),
		.pal_addr_o  (pal_bus_addr),
		.pal_wdata_o (pal_wdata),
		.pal_rdata_i (pal_bus_rdata),
		.prio_we_o   (prio_we),
		.prio_addr_o (prio_bus_addr),
		.prio_wdata_o(prio_wdata),
		.prio_rdata_i(prio_bus_rdata)
	);

	lookup_ram #(
		.entry_t(rgb_t),
		.DEPTH  (PAL_DEPTH)
	) u_palette (
		.clk_i    (V_BLANK),
		.we_i     (pal_we),
		.waddr_i  (pal_bus_addr),
		.wdata_i  (pal_wdata),
		.raddr_a_i(pal_pix_addr),
		.rdata_a_o(pal_pix_rdata),
		.raddr_b_i(pal_bus_addr),	// Also the read-modify-write source
		.rdata_b_o(pal_bus_rdata)
	);

	lookup_ram #(
		.entry_t(prio_entry_t),
		.DEPTH  (PRI_DEPTH)
	) u_prio_table (
		.clk_i    (V_BLANK),
		.we_i     (prio_we),
		.waddr_i  (prio_bus_addr),
		.wdata_i  (prio_wdata),
		.raddr_a_i(prio_pix_addr),
		.rdata_a_o(prio_pix_rdata),
		.raddr_b_i(prio_bus_addr),
		.rdata_b_o(prio_bus_rdata)
	);

	// ==========================================================================
	// Pixel side
	// ==========================================================================
	layer_priority_mux #(
		.PAL_DEPTH(PAL_DEPTH),
		.PRI_DEPTH(PRI_DEPTH)
	) u_mux (
		.V_BLANK     (V_BLANK),
		.EXROM2      (EXROM2),
		.pix_i       (pix_i),
		.cfg_i       (cfg),
		.prio_addr_o (prio_pix_addr),
		.prio_entry_i(prio_pix_rdata),
		.pal_addr_o  (pal_pix_addr),
		.pal_entry_i (pal_pix_rdata),
		.rgb_o       (rgb_o)
	);

	collision_detect u_collision (
		.V_BLANK    (V_BLANK),
		.EXROM2     (EXROM2),
		.pix_i      (pix_i),
		.clear_i    (hit_clear),
		.hit_flags_o(hit_flags)
	);

endmodule

/* test/tb_video_mixer.sv */
// Testbench of the colour mixer, replays the golden command file over APB and the pixel inputs
module tb_video_mixer
	import mixer_cfg_pkg::*, pixel_pkg::*;
();

	localparam GOLDEN_FILE = "test/mixer_golden.txt";
	localparam layer_pix_t IDLE_PIX = 14'h0001;	// Blanked, all layers transparent

	typedef struct packed {
		logic [7:0]  op;
		logic [11:0] addr;
		logic [7:0]  data;	// Write data or expected read data
		logic        err;
		layer_pix_t  pix;
		rgb_t        rgb;
	} golden_cmd_t;

	logic        clk;
	logic        rst_n;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	layer_pix_t  pix;
	rgb_t        rgb;

	golden_cmd_t cmds[$];
	int          n_lines = 0;
	int          rgb_errors = 0;
	int          apb_errors = 0;
	int          other_errors = 0;
	int          pix_sent = 0;
	int          pix_checked = 0;
	logic        chk_vld = 1'b0;
	rgb_t        chk_rgb;
	logic [3:0]  vld_pipe = '0;
	rgb_t [3:0]  exp_pipe;

	video_mixer_top #(
		.PAL_DEPTH(PALETTE_DEPTH),
		.PRI_DEPTH(PRIO_DEPTH)
	) i_dut (
		.V_BLANK  (clk),
		.EXROM2   (rst_n),
		.apb_req_i(apb_req),
		.apb_rsp_o(apb_rsp),
		.pix_i    (pix),
		.rgb_o    (rgb)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ==========================================================================
	// Golden file parsing
	// ==========================================================================
	task automatic load_golden();
		int               fd;
		int               code;
		logic             ok;
		logic [7:0]       op;
		logic [31:0]      f0, f1, f2, f3, f4, f5;
		logic [8*256-1:0] rest;
		golden_cmd_t      c;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			other_errors++;
			$display("Cannot open %s for reading", GOLDEN_FILE);
			return;
		end
		code = $fscanf(fd, " %c", op);
		while (code == 1) begin
			n_lines++;
			ok   = 1'b1;
			c    = '0;
			c.op = op;
			case (op)
				"W", "R": begin
					code   = $fscanf(fd, "%h %h %h", f0, f1, f2);
					ok     = (code == 3);
					c.addr = f0[11:0];
					c.data = f1[7:0];
					c.err  = f2[0];
					cmds.push_back(c);
				end
				"P": begin
					code        = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
					ok          = (code == 6);
					c.pix.tile1 = f0[2:0];
					c.pix.tile2 = f1[2:0];
					c.pix.tile3 = f2[2:0];
					c.pix.sprite = f3[3:0];
					c.pix.blank = f4[0];
					c.rgb       = f5[8:0];
					cmds.push_back(c);
				end
				"#": code = $fgets(rest, fd);	// Comment line
				default: begin
					ok   = 1'b0;
					code = $fgets(rest, fd);
				end
			endcase
			if (!ok) begin
				other_errors++;
				$display("Line %0d of the golden file is malformed", n_lines);
			end
			code = $fscanf(fd, " %c", op);
		end
		$fclose(fd);
	endtask

	// ==========================================================================
	// Stimulus
	// ==========================================================================
	task automatic apb_transfer(input golden_cmd_t c);
		apb_req_t   req;
		int         waits;
		logic       done;
		logic       err;
		logic [7:0] rdata;
		req        = '0;
		req.paddr  = c.addr;
		req.psel   = 1'b1;
		req.pwrite = (c.op == "W");
		req.pwdata = req.pwrite ? c.data : 8'h00;
		@(posedge clk);
		apb_req <= req;	// Setup phase
		pix     <= IDLE_PIX;
		chk_vld <= 1'b0;
		req.penable = 1'b1;
		@(posedge clk);
		apb_req <= req;
		waits = 0;
		@(negedge clk);
		while (apb_rsp.pready !== 1'b1 && waits < 8) begin
			waits++;
			@(negedge clk);
		end
		done  = (apb_rsp.pready === 1'b1);
		err   = apb_rsp.pslverr;
		rdata = apb_rsp.prdata;
		@(posedge clk);
		apb_req <= '0;	// Transfer ends on this edge
		assert (done) else begin
			other_errors++;
			$display("APB transfer to address %h never raised pready", c.addr);
		end
		assert (err === c.err) else begin
			apb_errors++;
			$display("[ERROR] %0t pslverr at %h: got %b, expected %b", $time, c.addr, err, c.err);
		end
		if (c.op == "R") begin
			assert (rdata === c.data) else begin
				apb_errors++;
				$display("[ERROR] %0t prdata at %h: got %h, expected %h", $time, c.addr, rdata,
					c.data);
			end
		end
	endtask

	task automatic drive_pixel(input golden_cmd_t c);
		@(posedge clk);
		pix     <= c.pix;
		chk_vld <= 1'b1;
		chk_rgb <= c.rgb;
		pix_sent++;
	endtask

	// Pixel on the input at this negedge is sampled next edge, RGB follows 3 edges later
	always @(negedge clk) begin
		if (vld_pipe[3]) begin
			pix_checked++;
			assert (rgb === exp_pipe[3]) else begin
				rgb_errors++;
				$display("[ERROR] %0t rgb_o: got %h, expected %h", $time, rgb, exp_pipe[3]);
			end
		end
		vld_pipe <= {vld_pipe[2:0], chk_vld};
		exp_pipe <= {exp_pipe[2:0], chk_rgb};
	end

	initial begin
		apb_req = '0;
		pix     = IDLE_PIX;
		rst_n   = 1'b0;
		load_golden();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		foreach (cmds[i]) begin
			if (cmds[i].op == "P") begin
				drive_pixel(cmds[i]);
			end else begin
				apb_transfer(cmds[i]);
			end
		end
		@(posedge clk);
		pix     <= IDLE_PIX;
		chk_vld <= 1'b0;
		wait (pix_checked == pix_sent);	// Drain the pipeline
		$display("Pixels checked %0d, errors: rgb %0d, apb %0d, other %0d",
			pix_checked, rgb_errors, apb_errors, other_errors);
		if (rgb_errors + apb_errors + other_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Watchdog, budget scales with the golden file length
	initial begin
		wait (n_lines > 0);
		repeat (n_lines * 20 + 100) @(posedge clk);
		$display("Timeout, the golden sequence of %0d lines did not finish", n_lines);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

/* sources.f */
src/mixer_cfg_pkg.sv
src/pixel_pkg.sv
src/lookup_ram.sv
src/mixer_regs.sv
src/layer_priority_mux.sv
src/collision_detect.sv
src/video_mixer_top.sv
test/tb_video_mixer.sv

/* Bender.yml */
package:
  name: video_mixer

sources:
  # Packages first, the modules import them
  - src/mixer_cfg_pkg.sv
  - src/pixel_pkg.sv
  # RTL, leaf modules before the top level
  - src/lookup_ram.sv
  - src/mixer_regs.sv
  - src/layer_priority_mux.sv
  - src/collision_detect.sv
  - src/video_mixer_top.sv
  # Testbench
  - target: test
    files:
      - test/tb_video_mixer.sv

/* test/mixer_golden.txt */
# W addr data pslverr / R addr expected_data pslverr, all hex
# P tile1 tile2 tile3 sprite blank expected_rgb, all hex
W 000 53 0
W 004 26 0
W 008 03 0
R 000 53 0
R 004 26 0
R 008 03 0
R 040 00 1
W 00C 55 1
W 8C0 04 0
W 8C4 0D 0
W 8DC 03 0
R 8C4 0D 0
W 194 A5 0
W 196 01 0
W 168 C3 0
W 16A 00 0
W 1C4 E7 0
W 1C6 00 0
W 1A0 8E 0
W 1A2 01 0
R 194 A5 0
R 196 01 0
P 7 7 7 7 1 000
R 00C 00 0
P 2 4 1 5 0 1A5
P 2 4 1 8 0 0C3
P 0 0 1 8 0 0E7
R 00C 07 0
W 010 00 0
R 00C 00 0
W 008 13 0
P 2 4 1 5 0 0C3
P 2 4 1 8 0 0E7
P 0 0 1 8 0 18E
R 008 13 0
